//--- isa_pkg.sv
package isa_pkg;

    // datapath widths
    localparam int DATA_WIDTH = 32;                      // data and byte address width
    localparam int REG_ADDR_WIDTH = 5;                   // register index width

    // register file
    localparam int REG_COUNT = 32;                       // architectural registers, x0 hardwired
    localparam logic [REG_ADDR_WIDTH-1:0] LINK_REG = 5'd31; // target of the return address

    // data memory
    localparam int MEM_ADDR_WIDTH = 8;                   // word address width
    localparam int MEM_DEPTH = 1 << MEM_ADDR_WIDTH;      // number of words

    // byte offset dropped when a byte address becomes a word address
    localparam int WORD_OFFSET = 2;

endpackage

//--- pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    // execute result, enters the ex/mem stage register
    typedef struct packed {
        logic [DATA_WIDTH-1:0]     pc_4;                 // return address for link ops
        logic [DATA_WIDTH-1:0]     alu_result;           // result or byte address of load/store
        logic [DATA_WIDTH-1:0]     store_data;           // word written by a store
        logic [REG_ADDR_WIDTH-1:0] dest_reg;             // destination register index
        logic                      reg_write;            // item writes the register file
        logic                      mem_read;             // load
        logic                      mem_write;            // store
        logic                      link;                 // write pc_4 into LINK_REG
    } ex_mem_t;

    // memory result, enters the mem/wb stage register
    typedef struct packed {
        logic [DATA_WIDTH-1:0]     pc_4;                 // passed through for link
        logic [DATA_WIDTH-1:0]     alu_result;           // alu value for plain ops
        logic [DATA_WIDTH-1:0]     mem_read_data;        // load data, valid when mem_read
        logic [REG_ADDR_WIDTH-1:0] dest_reg;             // destination register index
        logic                      reg_write;            // write enable for wb
        logic                      mem_read;             // select load data in wb
        logic                      link;                 // select pc_4 in wb
    } mem_wb_t;

    // request on the shared data memory bus
    typedef struct packed {
        logic                      write;                // 1 write, 0 read
        logic [MEM_ADDR_WIDTH-1:0] addr;                 // word address
        logic [DATA_WIDTH-1:0]     wdata;                // ignored on reads
    } mem_req_t;

    // clients of the data memory arbiter
    typedef enum logic {
        CLIENT_PIPE = 1'b0,                              // memory stage of the pipeline
        CLIENT_HOST = 1'b1                               // external host port
    } client_e;

endpackage

//--- pipe_stage_reg.sv
`timescale 1ns/1ns

module pipe_stage_reg #(
    parameter type payload_t = logic                     // stage payload, a packed struct
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,                           // upstream has an item
    output logic     in_ready,                           // stage can take an item
    input  payload_t in_data,
    output logic     out_valid,                          // stage holds an item
    input  logic     out_ready,                          // downstream takes the item
    output payload_t out_data
);

    logic load;                                          // input transfer this cycle

    // free when empty or when the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    // occupancy, a drain with no new item leaves a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;                       // refill or go empty
        end
    end

    // payload only moves on a transfer, held otherwise
    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= in_data;
        end
    end

endmodule

//--- mem_access.sv
`timescale 1ns/1ns

module mem_access (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             em_valid,
    output logic                             em_ready,
    input  pipe_pkg::ex_mem_t                em_data,
    output logic                             pipe_req_valid,
    input  logic                             pipe_req_ready,
    output pipe_pkg::mem_req_t               pipe_req,
    input  logic                             pipe_rsp_valid,
    input  logic [isa_pkg::DATA_WIDTH-1:0]   rd_data,
    output logic                             mw_in_valid,
    input  logic                             mw_in_ready,
    output pipe_pkg::mem_wb_t                mw_in_data
);

    import isa_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,                                          // no memory op in progress
        S_LOAD,                                          // load granted, waiting for data
        S_DONE                                           // memory work done, waiting for mw_in_ready
    } state_e;

    state_e                state_q, state_d;
    logic [DATA_WIDTH-1:0] rd_q;                         // captured load data
    logic                  is_load, is_store;

    assign is_load  = em_data.mem_read;
    assign is_store = em_data.mem_write && !em_data.mem_read; // load wins if both set

    // request payload straight from the held item, byte address to word address
    assign pipe_req.write = is_store;
    assign pipe_req.addr  = em_data.alu_result[MEM_ADDR_WIDTH+WORD_OFFSET-1:WORD_OFFSET];
    assign pipe_req.wdata = em_data.store_data;

    always_comb begin
        state_d        = state_q;
        pipe_req_valid = 1'b0;
        mw_in_valid    = 1'b0;
        em_ready       = 1'b0;
        case (state_q)
            S_IDLE: begin
                pipe_req_valid = em_valid && (is_load || is_store);
                if (!is_load && !is_store) begin
                    mw_in_valid = em_valid;              // plain op passes through
                    em_ready    = mw_in_ready;
                end else if (is_store) begin
                    mw_in_valid = em_valid && pipe_req_ready; // done on grant
                    em_ready    = pipe_req_ready && mw_in_ready;
                    if (em_valid && pipe_req_ready && !mw_in_ready) begin
                        state_d = S_DONE;                // written, not yet forwarded
                    end
                end else if (em_valid && pipe_req_ready) begin
                    state_d = S_LOAD;                    // read issued
                end
            end
            S_LOAD: begin
                mw_in_valid = pipe_rsp_valid;            // forward with the data
                em_ready    = pipe_rsp_valid && mw_in_ready;
                if (pipe_rsp_valid) begin
                    state_d = mw_in_ready ? S_IDLE : S_DONE;
                end
            end
            default: begin
                mw_in_valid = 1'b1;                      // S_DONE, result held
                em_ready    = mw_in_ready;
                if (mw_in_ready) begin
                    state_d = S_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // keep load data in case the next stage is stalled
    always_ff @(posedge clk) begin
        if (state_q == S_LOAD && pipe_rsp_valid) begin
            rd_q <= rd_data;
        end
    end

    assign mw_in_data.pc_4          = em_data.pc_4;
    assign mw_in_data.alu_result    = em_data.alu_result;
    assign mw_in_data.mem_read_data = (state_q == S_DONE) ? rd_q : rd_data;
    assign mw_in_data.dest_reg      = em_data.dest_reg;
    assign mw_in_data.reg_write     = em_data.reg_write;
    assign mw_in_data.mem_read      = is_load;
    assign mw_in_data.link          = em_data.link;

endmodule

//--- data_mem_arbiter.sv
`timescale 1ns/1ns

module data_mem_arbiter (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 pipe_req_valid,
    input  pipe_pkg::mem_req_t                   pipe_req,
    output logic                                 pipe_req_ready,
    output logic                                 pipe_rsp_valid,
    input  logic                                 host_req_valid,
    input  pipe_pkg::mem_req_t                   host_req,
    output logic                                 host_req_ready,
    output logic                                 host_rsp_valid,
    output logic [isa_pkg::DATA_WIDTH-1:0]       rsp_data,
    output logic                                 mem_en,
    output logic                                 mem_we,
    output logic [isa_pkg::MEM_ADDR_WIDTH-1:0]   mem_addr,
    output logic [isa_pkg::DATA_WIDTH-1:0]       mem_wdata,
    input  logic [isa_pkg::DATA_WIDTH-1:0]       mem_rdata
);

    import pipe_pkg::*;

    client_e  last_q;                                    // winner of the last grant
    client_e  rd_client_q;                               // owner of the read in flight
    logic     rd_pend_q;                                 // read issued last cycle
    logic     grant_pipe, grant_host;
    mem_req_t sel_req;

    // pipe wins alone, or on a tie when host won last
    assign grant_pipe = pipe_req_valid && (!host_req_valid || last_q == CLIENT_HOST);
    assign grant_host = host_req_valid && !grant_pipe;

    assign pipe_req_ready = grant_pipe;
    assign host_req_ready = grant_host;

    assign sel_req   = grant_host ? host_req : pipe_req;
    assign mem_en    = grant_pipe || grant_host;
    assign mem_we    = mem_en && sel_req.write;
    assign mem_addr  = sel_req.addr;
    assign mem_wdata = sel_req.wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q      <= CLIENT_HOST;                  // pipe takes the first tie
            rd_client_q <= CLIENT_PIPE;
            rd_pend_q   <= 1'b0;
        end else begin
            if (mem_en) begin
                last_q <= grant_host ? CLIENT_HOST : CLIENT_PIPE;
            end
            rd_pend_q <= mem_en && !sel_req.write;       // writes give no response
            if (mem_en) begin
                rd_client_q <= grant_host ? CLIENT_HOST : CLIENT_PIPE;
            end
        end
    end

    // steer the response to the client that issued the read
    assign pipe_rsp_valid = rd_pend_q && (rd_client_q == CLIENT_PIPE);
    assign host_rsp_valid = rd_pend_q && (rd_client_q == CLIENT_HOST);
    assign rsp_data       = mem_rdata;                   // shared, qualified by the valids

endmodule

//--- data_mem.sv
`timescale 1ns/1ns

module data_mem (
    input  logic                               clk,
    input  logic                               mem_en,    // access this cycle
    input  logic                               mem_we,    // write when enabled
    input  logic [isa_pkg::MEM_ADDR_WIDTH-1:0] mem_addr,  // word address
    input  logic [isa_pkg::DATA_WIDTH-1:0]     mem_wdata,
    output logic [isa_pkg::DATA_WIDTH-1:0]     mem_rdata  // one cycle after mem_en
);

    import isa_pkg::*;

    logic [DATA_WIDTH-1:0] mem_array [MEM_DEPTH];         // contents undefined until written

    // single port, read returns the old word on a write
    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                mem_array[mem_addr] <= mem_wdata;
            end
            mem_rdata <= mem_array[mem_addr];
        end
    end

endmodule

//--- wb_regfile.sv
`timescale 1ns/1ns

module wb_regfile (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               wb_valid,  // item present this cycle
    input  pipe_pkg::mem_wb_t                  wb_data,
    input  logic [isa_pkg::REG_ADDR_WIDTH-1:0] rs1_addr,
    output logic [isa_pkg::DATA_WIDTH-1:0]     rs1_data,
    input  logic [isa_pkg::REG_ADDR_WIDTH-1:0] rs2_addr,
    output logic [isa_pkg::DATA_WIDTH-1:0]     rs2_data
);

    import isa_pkg::*;

    logic [DATA_WIDTH-1:0]     regs [REG_COUNT];
    logic [REG_ADDR_WIDTH-1:0] wr_addr;
    logic [DATA_WIDTH-1:0]     wr_data;
    logic                      wr_en;

    // link overrides the destination and the data source
    assign wr_addr = wb_data.link ? LINK_REG : wb_data.dest_reg;

    always_comb begin
        if (wb_data.link) begin
            wr_data = wb_data.pc_4;                      // return address
        end else if (wb_data.mem_read) begin
            wr_data = wb_data.mem_read_data;             // load result
        end else begin
            wr_data = wb_data.alu_result;
        end
    end

    // x0 is never written
    assign wr_en = wb_valid && wb_data.reg_write && (wr_addr != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // read ports see the write from the next cycle on, no bypass
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- mem_wb_top.sv
`timescale 1ns/1ns

module mem_wb_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               ex_valid,
    output logic                               ex_ready,
    input  pipe_pkg::ex_mem_t                  ex_data,
    input  logic                               host_req_valid,
    output logic                               host_req_ready,
    input  pipe_pkg::mem_req_t                 host_req,
    output logic                               host_rsp_valid,
    output logic [isa_pkg::DATA_WIDTH-1:0]     host_rsp_data,
    input  logic [isa_pkg::REG_ADDR_WIDTH-1:0] rs1_addr,
    output logic [isa_pkg::DATA_WIDTH-1:0]     rs1_data,
    input  logic [isa_pkg::REG_ADDR_WIDTH-1:0] rs2_addr,
    output logic [isa_pkg::DATA_WIDTH-1:0]     rs2_data
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic                      em_valid, em_ready;      // ex/mem register to mem stage
    ex_mem_t                   em_data;
    logic                      pipe_req_valid, pipe_req_ready, pipe_rsp_valid;
    mem_req_t                  pipe_req;
    logic [DATA_WIDTH-1:0]     rd_data;                  // shared response data
    logic                      mem_en, mem_we;
    logic [MEM_ADDR_WIDTH-1:0] mem_addr;
    logic [DATA_WIDTH-1:0]     mem_wdata, mem_rdata;
    logic                      mw_in_valid, mw_in_ready; // mem stage to mem/wb register
    mem_wb_t                   mw_in_data;
    logic                      wb_valid, wb_ready;
    mem_wb_t                   wb_data;

    assign wb_ready      = 1'b1;                         // write-back never stalls
    assign host_rsp_data = rd_data;

    pipe_stage_reg #(.payload_t(ex_mem_t)) ex_mem_stage (
        .clk, .rst_n,
        .in_valid(ex_valid), .in_ready(ex_ready), .in_data(ex_data),
        .out_valid(em_valid), .out_ready(em_ready), .out_data(em_data)
    );

    mem_access u_mem_access (
        .clk, .rst_n, .em_valid, .em_ready, .em_data,
        .pipe_req_valid, .pipe_req_ready, .pipe_req, .pipe_rsp_valid, .rd_data,
        .mw_in_valid, .mw_in_ready, .mw_in_data
    );

    data_mem_arbiter u_arbiter (
        .clk, .rst_n, .pipe_req_valid, .pipe_req, .pipe_req_ready, .pipe_rsp_valid,
        .host_req_valid, .host_req, .host_req_ready, .host_rsp_valid,
        .rsp_data(rd_data), .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
    );

    data_mem u_data_mem (
        .clk, .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
    );

    pipe_stage_reg #(.payload_t(mem_wb_t)) mem_wb_stage (
        .clk, .rst_n,
        .in_valid(mw_in_valid), .in_ready(mw_in_ready), .in_data(mw_in_data),
        .out_valid(wb_valid), .out_ready(wb_ready), .out_data(wb_data)
    );

    wb_regfile u_regfile (
        .clk, .rst_n, .wb_valid, .wb_data,
        .rs1_addr, .rs1_data, .rs2_addr, .rs2_data
    );

endmodule

//--- mem_wb_sva.sv
`timescale 1ns/1ns

module mem_wb_sva (
    input logic               clk,
    input logic               rst_n,
    input logic               ex_valid,
    input logic               ex_ready,
    input pipe_pkg::ex_mem_t  ex_data,
    input logic               host_req_valid,
    input logic               host_req_ready,
    input pipe_pkg::mem_req_t host_req,
    input logic               host_rsp_valid,
    input logic               em_valid,
    input logic               wb_valid,
    input logic               pipe_req_valid,
    input logic               pipe_req_ready
);

    int failures;                                        // failed assertions so far

    // a stalled sender keeps valid and payload
    ex_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid && !ex_ready |=> ex_valid && $stable(ex_data))
        else begin
            $error("ex payload changed while stalled");
            failures++;
        end
    host_hold: assert property (@(posedge clk) disable iff (!rst_n)
        host_req_valid && !host_req_ready |=> host_req_valid && $stable(host_req))
        else begin
            $error("host request changed while stalled");
            failures++;
        end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !em_valid && !wb_valid && !host_rsp_valid)
        else begin
            $error("valid output high during reset");
            failures++;
        end

    // a loser always wins the next round
    pipe_grant: assert property (@(posedge clk) disable iff (!rst_n)
        pipe_req_valid && !pipe_req_ready |=> pipe_req_ready)
        else begin
            $error("pipe request starved");
            failures++;
        end
    host_grant: assert property (@(posedge clk) disable iff (!rst_n)
        host_req_valid && !host_req_ready |=> host_req_ready)
        else begin
            $error("host request starved");
            failures++;
        end

    host_rsp_follows: assert property (@(posedge clk) disable iff (!rst_n)
        host_req_valid && host_req_ready && !host_req.write |=> host_rsp_valid)
        else begin
            $error("host read gave no response");
            failures++;
        end
    host_rsp_only: assert property (@(posedge clk) disable iff (!rst_n)
        host_rsp_valid |-> $past(host_req_valid && host_req_ready && !host_req.write))
        else begin
            $error("host response without a read");
            failures++;
        end

endmodule

//--- tb_mem_wb.sv
`timescale 1ns/1ns

module tb_mem_wb;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int TIMEOUT = 200;                        // cycles allowed per wait

    logic                      clk, rst_n;
    logic                      ex_valid, ex_ready;
    ex_mem_t                   ex_data;
    logic                      host_req_valid, host_req_ready, host_rsp_valid;
    mem_req_t                  host_req;
    logic [DATA_WIDTH-1:0]     host_rsp_data, rs1_data, rs2_data;
    logic [REG_ADDR_WIDTH-1:0] rs1_addr, rs2_addr;

    logic [DATA_WIDTH-1:0]     model_regs [REG_COUNT];   // expected register file
    logic [DATA_WIDTH-1:0]     model_mem [MEM_DEPTH];    // expected memory words
    logic [MEM_ADDR_WIDTH-1:0] addrs [8];                // words written by the store test
    integer                    seed;
    int                        errors, checks, tests, errors_at_start;
    string                     cur_test;

    mem_wb_top UUT (.*);

    bind mem_wb_top mem_wb_sva sva_checks (
        .clk, .rst_n, .ex_valid, .ex_ready, .ex_data, .host_req_valid, .host_req_ready,
        .host_req, .host_rsp_valid, .em_valid, .wb_valid, .pipe_req_valid, .pipe_req_ready
    );

    always #4 clk = ~clk;                                // 8 ns period

    function automatic logic [DATA_WIDTH-1:0] rand_word();
        rand_word = $random(seed);
    endfunction

    // word index to the byte address carried in alu_result
    function automatic logic [DATA_WIDTH-1:0] byte_addr(input logic [MEM_ADDR_WIDTH-1:0] word);
        byte_addr = {{(DATA_WIDTH-MEM_ADDR_WIDTH-2){1'b0}}, word, 2'b00};
    endfunction

    function automatic ex_mem_t make_op(input logic load, store, wr, lnk,
                                        input logic [REG_ADDR_WIDTH-1:0] dest,
                                        input logic [DATA_WIDTH-1:0] alu, sdata);
        make_op            = '0;
        make_op.pc_4       = rand_word();
        make_op.alu_result = alu;
        make_op.store_data = sdata;
        make_op.dest_reg   = dest;
        make_op.reg_write  = wr;
        make_op.mem_read   = load;
        make_op.mem_write  = store;
        make_op.link       = lnk;
    endfunction

    task automatic timeout(input string what);
        $display("%s: timed out, %s", cur_test, what);
        errors++;
    endtask

    task automatic check_value(input string what, input logic [DATA_WIDTH-1:0] expected, actual);
        checks++;
        assert (actual === expected) else begin
            $display("ERROR %s: %s expected %h actual %h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    // model update in program order, then the ex handshake
    task automatic send_op(input ex_mem_t op);
        logic [MEM_ADDR_WIDTH-1:0] waddr;
        logic [REG_ADDR_WIDTH-1:0] target;
        int n;
        waddr  = op.alu_result[MEM_ADDR_WIDTH+1:2];
        target = op.link ? LINK_REG : op.dest_reg;       // link always goes to x31
        if (op.mem_write && !op.mem_read) begin
            model_mem[waddr] = op.store_data;
        end
        if (op.reg_write && target != '0) begin
            model_regs[target] = op.link ? op.pc_4
                               : (op.mem_read ? model_mem[waddr] : op.alu_result);
        end
        ex_valid = 1'b1;
        ex_data  = op;
        n = 0;
        do begin
            @(negedge clk);                              // ready is settled here
            n++;
        end while (!ex_ready && n < TIMEOUT);
        if (!ex_ready) begin
            timeout("ex_ready stayed low");
        end
        @(posedge clk);
        #1;
        ex_valid = 1'b0;
    endtask

    task automatic host_access(input logic write, input logic [MEM_ADDR_WIDTH-1:0] addr,
                               input logic [DATA_WIDTH-1:0] data);
        int n;
        host_req_valid = 1'b1;
        host_req       = '{write: write, addr: addr, wdata: data};
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!host_req_ready && n < TIMEOUT);
        if (!host_req_ready) begin
            timeout("host request never granted");
        end
        @(posedge clk);
        #1;
        host_req_valid = 1'b0;
        if (write) begin
            model_mem[addr] = data;
        end else begin
            n = 0;
            do begin
                @(negedge clk);                          // response lands one cycle after grant
                n++;
            end while (!host_rsp_valid && n < TIMEOUT);
            if (!host_rsp_valid) begin
                timeout("no host read response");
            end else begin
                check_value($sformatf("host read %0d", addr), model_mem[addr], host_rsp_data);
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while ((UUT.em_valid || UUT.wb_valid) && n < TIMEOUT);
        if (UUT.em_valid || UUT.wb_valid) begin
            timeout("pipeline did not drain");
        end
        @(posedge clk);
        #1;
    endtask

    // both read ports sweep the whole file in opposite order, one pair per cycle
    task automatic check_regs();
        for (int i = 0; i < REG_COUNT; i++) begin
            rs1_addr = i[REG_ADDR_WIDTH-1:0];
            rs2_addr = REG_ADDR_WIDTH'(REG_COUNT - 1 - i);
            @(negedge clk);                              // combinational reads settled
            check_value($sformatf("x%0d", i), model_regs[i], rs1_data);
            check_value($sformatf("x%0d on rs2", rs2_addr), model_regs[rs2_addr], rs2_data);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic start_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("%-18s %s", cur_test, (errors == errors_at_start) ? "passed" : "failed");
    endtask

    initial begin
        logic [DATA_WIDTH-1:0] rnd;
        seed           = 32'hffbfb2ba;
        clk            = 1'b0;
        rst_n          = 1'b0;
        ex_valid       = 1'b0;
        ex_data        = '0;
        host_req_valid = 1'b0;
        host_req       = '0;
        rs1_addr       = '0;
        rs2_addr       = '0;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        for (int i = 0; i < REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);                       // reset held 4 cycles
        #1;
        rst_n = 1'b1;

        start_test("reset_state");
        check_value("host_rsp_valid", '0, 32'(host_rsp_valid));
        check_value("ex_ready", 32'd1, 32'(ex_ready));
        check_regs();
        end_test();

        start_test("alu_writeback");
        repeat (20) begin
            rnd = rand_word();
            send_op(make_op(1'b0, 1'b0, 1'b1, 1'b0, rnd[4:0], rand_word(), '0));
        end
        drain();
        check_regs();
        end_test();

        start_test("store_load");
        for (int i = 0; i < 8; i++) begin
            rnd      = rand_word();
            addrs[i] = {2'b00, rnd[5:0]};                // pipe keeps to the low words
            send_op(make_op(1'b0, 1'b1, 1'b0, 1'b0, '0, byte_addr(addrs[i]), rand_word()));
        end
        for (int i = 0; i < 8; i++) begin
            send_op(make_op(1'b1, 1'b0, 1'b1, 1'b0, REG_ADDR_WIDTH'(i + 1),
                            byte_addr(addrs[i]), '0));
        end
        drain();
        check_regs();
        end_test();

        start_test("link");
        repeat (3) begin
            rnd = rand_word();
            send_op(make_op(1'b0, 1'b0, 1'b1, 1'b1, rnd[4:0], rand_word(), '0));
        end
        drain();
        check_regs();
        end_test();

        start_test("zero_and_disabled");
        repeat (4) begin
            send_op(make_op(1'b0, 1'b0, 1'b1, 1'b0, '0, rand_word(), '0));
            rnd = rand_word();
            send_op(make_op(1'b0, 1'b0, 1'b0, 1'b0, rnd[4:0], rand_word(), '0));
            send_op(make_op(1'b1, 1'b0, 1'b0, 1'b0, rnd[4:0], byte_addr(addrs[0]), '0));
        end
        drain();
        check_regs();
        end_test();

        start_test("contention");
        for (int i = 0; i < 8; i++) begin
            host_access(1'b1, MEM_ADDR_WIDTH'(128 + i), rand_word()); // host owns the upper words
        end
        fork
            begin : pipe_side
                logic [DATA_WIDTH-1:0] r;
                for (int i = 0; i < 16; i++) begin
                    r = rand_word();
                    if (r[31]) begin
                        send_op(make_op(1'b0, 1'b1, 1'b0, 1'b0, '0, byte_addr(addrs[r[2:0]]), r));
                    end else begin
                        send_op(make_op(1'b1, 1'b0, 1'b1, 1'b0, r[12:8],
                                        byte_addr(addrs[r[2:0]]), '0));
                    end
                end
            end
            begin : host_side
                for (int i = 0; i < 16; i++) begin
                    host_access(i[0], MEM_ADDR_WIDTH'(128 + (i * 3) % 8), rand_word());
                end
            end
        join
        drain();
        check_regs();
        end_test();

        errors += UUT.sva_checks.failures;               // protocol assertion failures
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
isa_pkg.sv
pipe_pkg.sv
pipe_stage_reg.sv
mem_access.sv
data_mem_arbiter.sv
data_mem.sv
wb_regfile.sv
mem_wb_top.sv
mem_wb_sva.sv
tb_mem_wb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_wb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q -x "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
